//--- rtl/dir_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module dir_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              btn_up,
    input  logic              btn_left,
    input  logic              btn_down,
    input  logic              btn_right,
    output snake_pkg::dir_t   heading
);

    snake_pkg::dir_t next_heading;

    // priority up, left, down, right
    // a button pointing back into the body is ignored
    always_comb
    begin
        next_heading = heading;
        if (btn_up && heading != snake_pkg::dir_down)
            next_heading = snake_pkg::dir_up;
        else if (btn_left && heading != snake_pkg::dir_right)
            next_heading = snake_pkg::dir_left;
        else if (btn_down && heading != snake_pkg::dir_up)
            next_heading = snake_pkg::dir_down;
        else if (btn_right && heading != snake_pkg::dir_left)
            next_heading = snake_pkg::dir_right;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            heading <= snake_pkg::dir_right;  // game starts heading right
        end
        else
        begin
            heading <= next_heading;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pace_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "snake_macros.svh"

module pace_timer (
    input  logic                clk,
    input  logic                reset,
    input  logic                frame_tick,
    input  snake_pkg::length_t  length,
    output logic                step
);

    logic [4:0] pace;   // frames per game step
    logic [4:0] count;  // frames seen since the last step

    // longer snake, faster game
    always_comb
    begin
        if (length < `SNAKE_LEN_MID)
            pace = 5'(`SNAKE_PACE_SLOW);
        else if (length < `SNAKE_LEN_FAST)
            pace = 5'(`SNAKE_PACE_MID);
        else
            pace = 5'(`SNAKE_PACE_FAST);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
            step  <= 1'b0;
        end
        else
        begin
            step <= 1'b0;  // single cycle pulse
            if (frame_tick)
            begin
                // >= also catches a count left above a pace that just got shorter
                if (count + 5'd1 >= pace)
                begin
                    count <= '0;
                    step  <= 1'b1;
                end
                else
                begin
                    count <= count + 5'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/snake_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "snake_macros.svh"

module snake_engine (
    input  logic                clk,
    input  logic                reset,
    input  logic                step,
    input  snake_pkg::dir_t     heading,
    snake_state_if.engine       state,
    output snake_pkg::length_t  length,
    output snake_pkg::score_t   score
);

    localparam snake_pkg::block_pos_t start_head = '{
        x: 10'(`SNAKE_START_HEAD_X),
        y: 9'(`SNAKE_START_HEAD_Y)
    };
    localparam snake_pkg::block_pos_t start_tail = '{
        x: 10'(`SNAKE_START_HEAD_X),
        y: 9'(`SNAKE_START_TAIL_Y)
    };
    localparam snake_pkg::block_pos_t start_food = '{
        x: 10'(`SNAKE_START_FOOD_X),
        y: 9'(`SNAKE_START_FOOD_Y)
    };

    snake_pkg::block_pos_t body [`SNAKE_MAX_LEN];
    snake_pkg::block_pos_t food;
    snake_pkg::length_t    len;
    snake_pkg::score_t     score_q;

    logic                  hit_wall;
    logic                  hit_body;
    logic                  collide;
    logic                  eat;
    video_pkg::coord_x_t   dx;
    video_pkg::coord_y_t   dy;
    snake_pkg::length_t    grown_len;
    snake_pkg::length_t    next_len;
    logic [11:0]           food_sum_x;  // 2*x + x needs 12 bits
    logic [10:0]           food_sum_y;
    snake_pkg::block_pos_t next_food;
    snake_pkg::block_pos_t next_head;

    ////////////////////////////////////////
    // step decisions, all from the old state
    ////////////////////////////////////////

    assign hit_wall = (body[0].x == '0) || (body[0].x >= `SNAKE_FIELD_RIGHT) ||
                      (body[0].y <= `SNAKE_FIELD_TOP) || (body[0].y >= `SNAKE_FIELD_BOTTOM);

    // neck (index 1) can never overlap the head, start at 2
    always_comb
    begin
        hit_body = 1'b0;
        for (int i = 2; i < `SNAKE_MAX_LEN; i++)
        begin
            if (i < len && body[i] == body[0])
                hit_body = 1'b1;
        end
    end

    assign collide = hit_wall || hit_body;

    assign dx  = (body[0].x >= food.x) ? body[0].x - food.x : food.x - body[0].x;
    assign dy  = (body[0].y >= food.y) ? body[0].y - food.y : food.y - body[0].y;
    assign eat = (dx <= `SNAKE_BLOCK) && (dy <= `SNAKE_BLOCK);

    assign grown_len = (len < `SNAKE_MAX_LEN) ? len + 5'd1 : len;  // capped body
    assign next_len  = eat ? grown_len : len;

    // pseudo random food spot from head and neck
    assign food_sum_x  = {1'b0, body[0].x, 1'b0} + {2'b00, body[1].x};
    assign food_sum_y  = {1'b0, body[0].y, 1'b0} + {2'b00, body[1].y};
    assign next_food.x = 10'(`SNAKE_FOOD_BASE + food_sum_x % `SNAKE_FOOD_MOD_X);
    assign next_food.y = 9'(`SNAKE_FOOD_BASE + food_sum_y % `SNAKE_FOOD_MOD_Y);

    always_comb
    begin
        next_head = body[0];
        case (heading)
            snake_pkg::dir_left:  next_head.x = body[0].x - 10'(`SNAKE_BLOCK);
            snake_pkg::dir_right: next_head.x = body[0].x + 10'(`SNAKE_BLOCK);
            snake_pkg::dir_up:    next_head.y = body[0].y - 9'(`SNAKE_BLOCK);
            default:              next_head.y = body[0].y + 9'(`SNAKE_BLOCK);
        endcase
    end

    ////////////////////////////////////////
    // game state
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || (step && collide))
        begin
            // blocks 2 and up stay hidden behind the length
            body[0] <= start_head;
            body[1] <= start_tail;
            food    <= start_food;
            len     <= 5'd2;
            score_q <= '0;
        end
        else if (step)
        begin
            for (int i = 1; i < `SNAKE_MAX_LEN; i++)
            begin
                if (i < next_len)
                    body[i] <= body[i-1];  // follow the block in front
            end
            body[0] <= next_head;
            if (eat)
            begin
                score_q <= score_q + 8'd1;
                len     <= grown_len;
                food    <= next_food;
            end
        end
    end

    assign state.body   = body;
    assign state.length = len;
    assign state.food   = food;
    assign length       = len;
    assign score        = score_q;

endmodule

`default_nettype wire

//--- rtl/snake_macros.svh
`ifndef SNAKE_MACROS_SVH
`define SNAKE_MACROS_SVH

// block geometry and body limit
`define SNAKE_BLOCK         20
`define SNAKE_MAX_LEN       16

// play field edges, the snake dies on or beyond them
`define SNAKE_FIELD_RIGHT   640
`define SNAKE_FIELD_TOP     60
`define SNAKE_FIELD_BOTTOM  480
`define SNAKE_BAND_TOP      50   // status band sits between this and the field top

// start picture
`define SNAKE_START_HEAD_X  200
`define SNAKE_START_HEAD_Y  150
`define SNAKE_START_TAIL_Y  130
`define SNAKE_START_FOOD_X  300
`define SNAKE_START_FOOD_Y  200

// food relocation
`define SNAKE_FOOD_BASE     80
`define SNAKE_FOOD_MOD_X    450
`define SNAKE_FOOD_MOD_Y    320

// frames per step and the lengths where the pace changes
`define SNAKE_PACE_SLOW     16
`define SNAKE_PACE_MID      8
`define SNAKE_PACE_FAST     4
`define SNAKE_LEN_MID       5
`define SNAKE_LEN_FAST      12

`endif

//--- rtl/snake_pkg.sv
`default_nettype none

////////////////////////////////////////
// game side types
////////////////////////////////////////

package snake_pkg;

    // heading of the snake head
    typedef enum logic [1:0] {
        dir_left  = 2'd0,
        dir_right = 2'd1,
        dir_up    = 2'd2,
        dir_down  = 2'd3
    } dir_t;

    // top-left corner of one 20x20 block
    typedef struct packed {
        video_pkg::coord_x_t x;
        video_pkg::coord_y_t y;
    } block_pos_t;

    typedef logic [4:0] length_t;  // visible blocks, head included
    typedef logic [7:0] score_t;   // foods eaten since restart

endpackage

`default_nettype wire

//--- rtl/snake_renderer.sv
`timescale 1ns/100ps
`default_nettype none

`include "snake_macros.svh"

module snake_renderer (
    input  logic                 clk,
    input  logic                 reset,
    input  video_pkg::coord_x_t  pixel_x,
    input  video_pkg::coord_y_t  pixel_y,
    snake_state_if.renderer      state,
    output video_pkg::rgb_t      colour
);

    logic            on_food;
    logic            on_body;
    logic            on_band;
    video_pkg::rgb_t next_colour;

    // strictly inside the 20x20 square, so the block outline stays dark
    function automatic logic inside_block(video_pkg::coord_x_t px,
                                          video_pkg::coord_y_t py,
                                          snake_pkg::block_pos_t b);
        logic in_x;
        logic in_y;
        in_x = ({1'b0, px} > {1'b0, b.x}) && ({1'b0, px} < {1'b0, b.x} + 11'(`SNAKE_BLOCK));
        in_y = ({1'b0, py} > {1'b0, b.y}) && ({1'b0, py} < {1'b0, b.y} + 10'(`SNAKE_BLOCK));
        return in_x && in_y;
    endfunction

    assign on_food = inside_block(pixel_x, pixel_y, state.food);

    always_comb
    begin
        on_body = 1'b0;
        for (int i = 0; i < `SNAKE_MAX_LEN; i++)
        begin
            if (i < state.length && inside_block(pixel_x, pixel_y, state.body[i]))
                on_body = 1'b1;
        end
    end

    assign on_band = (pixel_x > 0) && (pixel_x < `SNAKE_FIELD_RIGHT) &&
                     (pixel_y > `SNAKE_BAND_TOP) && (pixel_y < `SNAKE_FIELD_TOP);

    // food drawn over the body, body over the band
    always_comb
    begin
        next_colour = '0;
        if (on_food)
            next_colour.green = 4'hf;
        else if (on_body)
            next_colour.blue = 4'hf;
        else if (on_band)
            next_colour.red = 4'hf;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            colour <= '0;  // black
        else
            colour <= next_colour;
    end

endmodule

`default_nettype wire

//--- rtl/snake_state_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "snake_macros.svh"

// snake picture handed from the game engine to the renderer
interface snake_state_if;

    snake_pkg::block_pos_t body [`SNAKE_MAX_LEN];  // index 0 is the head
    snake_pkg::length_t    length;
    snake_pkg::block_pos_t food;

    modport engine (
        output body, length, food
    );

    modport renderer (
        input body, length, food
    );

endinterface

`default_nettype wire

//--- rtl/snake_top.sv
`timescale 1ns/100ps
`default_nettype none

module snake_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 btn_up,
    input  logic                 btn_left,
    input  logic                 btn_down,
    input  logic                 btn_right,
    input  logic                 frame_tick,
    input  video_pkg::coord_x_t  pixel_x,
    input  video_pkg::coord_y_t  pixel_y,
    output logic [3:0]           red,
    output logic [3:0]           green,
    output logic [3:0]           blue,
    output snake_pkg::score_t    score
);

    snake_pkg::dir_t    heading;
    snake_pkg::length_t length;
    logic               step;
    video_pkg::rgb_t    colour;

    snake_state_if state_if ();

    dir_decoder dir_decoder_i (
        .clk       (clk),
        .reset     (reset),
        .btn_up    (btn_up),
        .btn_left  (btn_left),
        .btn_down  (btn_down),
        .btn_right (btn_right),
        .heading   (heading)
    );

    pace_timer pace_timer_i (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .length     (length),
        .step       (step)
    );

    snake_engine snake_engine_i (
        .clk     (clk),
        .reset   (reset),
        .step    (step),
        .heading (heading),
        .state   (state_if.engine),
        .length  (length),
        .score   (score)
    );

    snake_renderer snake_renderer_i (
        .clk     (clk),
        .reset   (reset),
        .pixel_x (pixel_x),
        .pixel_y (pixel_y),
        .state   (state_if.renderer),
        .colour  (colour)
    );

    // channel split for the DAC pins
    assign red   = colour.red;
    assign green = colour.green;
    assign blue  = colour.blue;

endmodule

`default_nettype wire

//--- rtl/video_pkg.sv
`default_nettype none

////////////////////////////////////////
// display side types
////////////////////////////////////////

package video_pkg;

    // raster position of the pixel being coloured
    typedef logic [9:0] coord_x_t;  // 0 to 1023
    typedef logic [8:0] coord_y_t;  // 0 to 511

    // one 12-bit colour word, red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the snake testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module snake_tb -o snake_sim

out=$(./obj_dir/snake_sim || true)
echo "$out"
echo "$out" | grep -q "All checks passed"

//--- tb/snake_stim.txt
# one command per line, press <up|left|down|right>, tick <n>, wait,
# probe <x> <y> <expected rgb in hex>, score <expected score>
probe 210 160 00f
probe 210 140 00f
probe 310 210 0f0
probe 320 55 f00
probe 320 300 000
score 0
tick 16
probe 230 160 00f
probe 210 160 00f
probe 210 140 000
tick 15
wait
probe 230 160 00f
probe 250 160 000
tick 1
probe 250 160 00f
press left
tick 16
probe 270 160 00f
probe 230 160 000
press down
tick 16
probe 270 180 00f
probe 250 160 000
tick 16
press right
tick 32
probe 270 200 00f
probe 460 340 0f0
score 1
press down
tick 112
press right
tick 128
probe 490 120 0f0
score 2
press up
tick 176
probe 120 180 0f0
score 3
tick 7
probe 470 100 000
tick 1
probe 470 100 00f
tick 24
probe 210 160 00f
probe 210 140 00f
probe 310 210 0f0
probe 320 55 f00
score 0

//--- tb/snake_tb.sv
`timescale 1ns/100ps
`default_nettype none

module snake_tb;

    localparam int op_press = 0;
    localparam int op_tick  = 1;
    localparam int op_wait  = 2;
    localparam int op_probe = 3;
    localparam int op_score = 4;

    logic                clk;
    logic                reset;
    logic [3:0]          buttons;  // up, left, down, right from bit 0
    logic                frame_tick;
    video_pkg::coord_x_t pixel_x;
    video_pkg::coord_y_t pixel_y;
    logic [3:0]          red;
    logic [3:0]          green;
    logic [3:0]          blue;
    snake_pkg::score_t   score;

    // one entry per command line of the stimulus file
    int op_q[$];
    int arg_a[$];
    int arg_b[$];
    int arg_c[$];
    int cycle_limit = 500;  // margin, commands add to it
    int cycles = 0;

    snake_top snake_top_i (
        .clk        (clk),
        .reset      (reset),
        .btn_up     (buttons[0]),
        .btn_left   (buttons[1]),
        .btn_down   (buttons[2]),
        .btn_right  (buttons[3]),
        .frame_tick (frame_tick),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .score      (score)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    ////////////////////////////////////////
    // failure and result checks
    ////////////////////////////////////////

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "stopped at %0t ns", $time);
    endtask

    task automatic check_colour(input video_pkg::rgb_t expected);
        video_pkg::rgb_t actual;
        actual = {red, green, blue};
        if (actual !== expected)
        begin
            $display("FAILED at %0t ns: colour at (%0d,%0d) expected %h, actual %h",
                     $time, pixel_x, pixel_y, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_score(input snake_pkg::score_t expected);
        if (score !== expected)
        begin
            $display("FAILED at %0t ns: score expected %0d, actual %0d",
                     $time, expected, score);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic load_commands();
        int              fd;
        int              rc;
        int              n_args;
        int              a;
        int              b;
        int              c;
        logic [8*8-1:0]  word;
        logic [8*100-1:0] line;
        fd = $fopen("tb/snake_stim.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open tb/snake_stim.txt");
            abort_run();
        end
        while ($fscanf(fd, "%s", word) == 1)
        begin
            a = 0;
            b = 0;
            c = 0;
            rc = 0;
            n_args = 0;
            if (word == "#")
            begin
                rc = $fgets(line, fd);  // rest of a comment line
                continue;
            end
            else if (word == "press")
            begin
                rc = $fscanf(fd, "%s", word);
                n_args = 1;
                op_q.push_back(op_press);
                a = (word == "up") ? 0 : (word == "left") ? 1 : (word == "down") ? 2 : 3;
            end
            else if (word == "tick")
            begin
                rc = $fscanf(fd, "%d", a);
                n_args = 1;
                op_q.push_back(op_tick);
            end
            else if (word == "wait")
                op_q.push_back(op_wait);
            else if (word == "probe")
            begin
                rc = $fscanf(fd, "%d %d %h", a, b, c);
                n_args = 3;
                op_q.push_back(op_probe);
            end
            else if (word == "score")
            begin
                rc = $fscanf(fd, "%d", a);
                n_args = 1;
                op_q.push_back(op_score);
            end
            else
            begin
                $display("unknown command in tb/snake_stim.txt");
                abort_run();
            end
            if (rc != n_args)
            begin
                $display("missing values after a command in tb/snake_stim.txt");
                abort_run();
            end
            arg_a.push_back(a);
            arg_b.push_back(b);
            arg_c.push_back(c);
            cycle_limit += (op_q[op_q.size()-1] == op_tick) ? 2 * a : 4;
        end
        $fclose(fd);
    endtask

    // every task below starts and ends on a falling edge
    task automatic press_button(input int which);
        buttons[which] = 1'b1;
        repeat (2) @(negedge clk);
        buttons = '0;
    endtask

    task automatic send_ticks(input int n);
        repeat (n)
        begin
            frame_tick = 1'b1;
            @(negedge clk);
            frame_tick = 1'b0;
            @(negedge clk);  // idle cycle
        end
    endtask

    task automatic probe_pixel(input int x, input int y, input video_pkg::rgb_t expected);
        pixel_x = video_pkg::coord_x_t'(x);
        pixel_y = video_pkg::coord_y_t'(y);
        @(negedge clk);
        check_colour(expected);
    endtask

    initial
    begin
        clk        = 1'b0;
        reset      = 1'b1;
        buttons    = '0;
        frame_tick = 1'b0;
        pixel_x    = '0;
        pixel_y    = '0;
        load_commands();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < op_q.size(); i++)
        begin
            case (op_q[i])
                op_press: press_button(arg_a[i]);
                op_tick:  send_ticks(arg_a[i]);
                op_wait:  repeat (4) @(negedge clk);
                op_probe: probe_pixel(arg_a[i], arg_b[i], arg_c[i][11:0]);
                default:  check_score(snake_pkg::score_t'(arg_a[i]));
            endcase
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/video_pkg.sv
rtl/snake_pkg.sv
rtl/snake_state_if.sv
rtl/dir_decoder.sv
rtl/pace_timer.sv
rtl/snake_engine.sv
rtl/snake_renderer.sv
rtl/snake_top.sv
tb/snake_tb.sv
